//--- files.f
hw/video_pkg.sv
hw/video_timing.sv
hw/tile_layer.sv
hw/color_mixer.sv
hw/video_top.sv
tests/tb_video_top.sv

//--- tests/tb_video_top.sv
/*
 * Testbench for the tile video subsystem
 * Models both graphics ROMs, loads maps and palette over the CPU
 * bus, applies a table of scroll, control and palette settings in
 * vertical blank and checks every pixel of the following frame
 */

`timescale 1ns/1ps
`default_nettype none

module tb_video_top import video_pkg::*; ();

    localparam int N_ROWS   = 8;
    localparam int TIMEOUT  = (N_ROWS + 2) * 2 * H_TOTAL * V_TOTAL * 2;
    localparam int SEL_L0   = 0;
    localparam int SEL_L1   = 1;
    localparam int SEL_PAL  = 2;
    localparam int SEL_CTRL = 3;

    logic              clk;
    logic              rst_n;
    logic [CPU_AW-1:0] cpu_addr;
    logic [CPU_DW-1:0] cpu_dout;
    logic              cpu_we;
    logic              layer0_cs;
    logic              layer1_cs;
    logic              pal_cs;
    logic              ctrl_cs;
    logic [ROM_DW-1:0] rom0_data = '0;
    logic [ROM_DW-1:0] rom1_data = '0;
    logic [ROM_AW-1:0] rom0_addr;
    logic [ROM_AW-1:0] rom1_addr;
    logic              hs;
    logic              vs;
    logic              lhbl_dly;
    logic              lvbl_dly;
    logic [7:0]        red;
    logic [7:0]        green;
    logic [7:0]        blue;

    // Reference copies of everything written to the DUT
    logic [ROM_DW-1:0] rom_img  [2][2**ROM_AW];
    logic [CPU_DW-1:0] map_copy [2][2**MAP_AW];
    logic [PAL_DW-1:0] pal_copy [2**PAL_AW];
    logic [MAP_XW-1:0] scr_h    [2];
    logic [MAP_YW-1:0] scr_v    [2];
    logic [2:0]        ctrl_copy = 3'b110;

    // Stimulus table, one row per checked frame
    logic [MAP_XW-1:0] tbl_sh0 [N_ROWS];
    logic [MAP_YW-1:0] tbl_sv0 [N_ROWS];
    logic [MAP_XW-1:0] tbl_sh1 [N_ROWS];
    logic [MAP_YW-1:0] tbl_sv1 [N_ROWS];
    logic [2:0]        tbl_ctrl [N_ROWS];
    logic              tbl_pal [N_ROWS];

    logic pix_phase;
    int   cycle_cnt = 0;
    logic hs_q = 1'b0;
    logic vs_q = 1'b0;
    logic vs_seen = 1'b0;
    int   hs_cnt = 0;
    int   pix_cnt = 0;

    video_top i_video_top (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_we    ( cpu_we    ),
        .layer0_cs ( layer0_cs ),
        .layer1_cs ( layer1_cs ),
        .pal_cs    ( pal_cs    ),
        .ctrl_cs   ( ctrl_cs   ),
        .rom0_data ( rom0_data ),
        .rom1_data ( rom1_data ),
        .rom0_addr ( rom0_addr ),
        .rom1_addr ( rom1_addr ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ROMs answer one clock after the address
    always @(posedge clk) begin
        rom0_data <= rom_img[0][rom0_addr];
        rom1_data <= rom_img[1][rom1_addr];
    end

    // Pixel clock phase, high on the edges where the DUT steps
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_phase <= 1'b0;
        end else begin
            pix_phase <= ~pix_phase;
        end
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT) begin
            abort_run($sformatf("Timeout: no result after %0d clock cycles", TIMEOUT));
        end
    end

    task automatic check_rgb(string name, logic [7:0] got_r, logic [7:0] got_g,
                             logic [7:0] got_b, logic [7:0] exp_r, logic [7:0] exp_g,
                             logic [7:0] exp_b);
        if ({got_r, got_g, got_b} !== {exp_r, exp_g, exp_b}) begin
            abort_run($sformatf("FAILED at %0t: %s got %02h_%02h_%02h expected %02h_%02h_%02h",
                                $time, name, got_r, got_g, got_b, exp_r, exp_g, exp_b));
        end
    endtask

    task automatic check_count(string name, int got, int expected);
        if (got != expected) begin
            abort_run($sformatf("FAILED at %0t: %s got %0d expected %0d",
                                $time, name, got, expected));
        end
    endtask

    // Sync pulses per frame, measured from one vs pulse to the next
    always @(posedge clk) begin
        if (rst_n && pix_phase) begin
            if (hs && !hs_q) begin
                hs_cnt = hs_cnt + 1;
            end
            if (vs && !vs_q) begin
                if (vs_seen) begin
                    check_count("hs pulses per vs", hs_cnt, V_TOTAL);
                    check_count("pixels per vs", pix_cnt, H_TOTAL * V_TOTAL);
                end
                vs_seen = 1'b1;
                hs_cnt  = 0;
                pix_cnt = 0;
            end
            pix_cnt = pix_cnt + 1;
            hs_q    = hs;
            vs_q    = vs;
        end
    end

    task automatic set_row(int r, int sh0, int sv0, int sh1, int sv1, int ctrl, bit pal);
        tbl_sh0[r]  = sh0;
        tbl_sv0[r]  = sv0;
        tbl_sh1[r]  = sh1;
        tbl_sv1[r]  = sv1;
        tbl_ctrl[r] = ctrl;
        tbl_pal[r]  = pal;
    endtask

    // Control bits are en1, en0, prio
    task automatic load_table();
        set_row(0,   0,  0,   0,  0, 3'b110, 1'b0);
        set_row(1, 127, 63, 120, 60, 3'b110, 1'b0);
        set_row(2,  90, 40,  85, 33, 3'b110, 1'b0);
        set_row(3,   5,  3,  17,  9, 3'b111, 1'b0);
        set_row(4,  33, 12,  70, 50, 3'b100, 1'b0);
        set_row(5, 101, 29,  44, 61, 3'b011, 1'b0);
        set_row(6,  12,  7,  99, 18, 3'b001, 1'b0);
        set_row(7,  64, 32,   0,  0, 3'b111, 1'b1);
    endtask

    // About a third of the nibbles are transparent
    task automatic fill_roms();
        logic [3:0] nib;
        for (int l = 0; l < 2; l++) begin
            for (int a = 0; a < 2**ROM_AW; a++) begin
                for (int k = 0; k < ROM_DW / 4; k++) begin
                    nib = $urandom_range(15, 1);
                    if ($urandom % 3 == 0) begin
                        nib = 4'd0;
                    end
                    rom_img[l][a][k*4 +: 4] = nib;
                end
            end
        end
    endtask

    task automatic cpu_write(int sel, logic [CPU_AW-1:0] addr, logic [CPU_DW-1:0] data);
        @(posedge clk);
        cpu_addr  <= addr;
        cpu_dout  <= data;
        cpu_we    <= 1'b1;
        layer0_cs <= (sel == SEL_L0);
        layer1_cs <= (sel == SEL_L1);
        pal_cs    <= (sel == SEL_PAL);
        ctrl_cs   <= (sel == SEL_CTRL);
    endtask

    task automatic cpu_idle();
        @(posedge clk);
        cpu_we    <= 1'b0;
        layer0_cs <= 1'b0;
        layer1_cs <= 1'b0;
        pal_cs    <= 1'b0;
        ctrl_cs   <= 1'b0;
    endtask

    task automatic rewrite_palette();
        for (int i = 0; i < 2**PAL_AW; i++) begin
            pal_copy[i] = $urandom;
            cpu_write(SEL_PAL, i, {4'd0, pal_copy[i]});
        end
    endtask

    task automatic fill_maps();
        for (int i = 0; i < 2**MAP_AW; i++) begin
            map_copy[0][i] = $urandom;
            map_copy[1][i] = $urandom;
            cpu_write(SEL_L0, i, map_copy[0][i]);
            cpu_write(SEL_L1, i, map_copy[1][i]);
        end
    endtask

    task automatic next_pixel();
        do begin
            @(posedge clk);
        end while (!pix_phase);
    endtask

    task automatic wait_vblank_start();
        do next_pixel(); while (!lvbl_dly);
        do next_pixel(); while (lvbl_dly);
    endtask

    // Palette number and colour index of one layer at a screen position
    function automatic logic [PXL_W-1:0] layer_pixel(int l, int x, int y);
        int          px;
        int          py;
        logic [15:0] entry;
        logic [31:0] word;
        px    = (x + scr_h[l]) % (MAP_COLS * TILE_SIZE);
        py    = (y + scr_v[l]) % (MAP_ROWS * TILE_SIZE);
        entry = map_copy[l][(py / TILE_SIZE) * MAP_COLS + px / TILE_SIZE];
        word  = rom_img[l][entry[7:0] * TILE_SIZE + py % TILE_SIZE];
        return {entry[11:8], word[(7 - px % TILE_SIZE) * 4 +: 4]};
    endfunction

    function automatic logic [PAL_DW-1:0] expected_colour(int x, int y);
        logic [PXL_W-1:0] lp [2];
        logic             vis [2];
        int               front;
        int               back;
        lp[0]  = layer_pixel(0, x, y);
        lp[1]  = layer_pixel(1, x, y);
        vis[0] = ctrl_copy[CTRL_EN0_BIT] && (lp[0][3:0] != 4'd0);
        vis[1] = ctrl_copy[CTRL_EN1_BIT] && (lp[1][3:0] != 4'd0);
        // Layer 1 is in front unless the priority bit swaps them
        front  = ctrl_copy[CTRL_PRIO_BIT] ? 0 : 1;
        back   = 1 - front;
        if (vis[front]) begin
            return pal_copy[{front[0], lp[front]}];
        end
        if (vis[back]) begin
            return pal_copy[{back[0], lp[back]}];
        end
        return pal_copy[0];
    endfunction

    task automatic apply_row(int r);
        cpu_write(SEL_L0, SCROLL_H_ADDR, tbl_sh0[r]);
        cpu_write(SEL_L0, SCROLL_V_ADDR, tbl_sv0[r]);
        cpu_write(SEL_L1, SCROLL_H_ADDR, tbl_sh1[r]);
        cpu_write(SEL_L1, SCROLL_V_ADDR, tbl_sv1[r]);
        cpu_write(SEL_CTRL, 0, tbl_ctrl[r]);
        if (tbl_pal[r]) begin
            rewrite_palette();
        end
        cpu_idle();
        scr_h[0]  = tbl_sh0[r];
        scr_v[0]  = tbl_sv0[r];
        scr_h[1]  = tbl_sh1[r];
        scr_v[1]  = tbl_sv1[r];
        ctrl_copy = tbl_ctrl[r];
    endtask

    // Runs until the delayed vertical blank of the next frame begins
    task automatic check_frame(int r);
        int                x;
        int                y;
        logic              seen;
        logic              was_active;
        logic [PAL_DW-1:0] c;
        x          = 0;
        y          = 0;
        seen       = 1'b0;
        was_active = 1'b0;
        forever begin
            next_pixel();
            if (lvbl_dly) begin
                seen = 1'b1;
            end else if (seen) begin
                break;
            end
            if (lhbl_dly && lvbl_dly) begin
                c = expected_colour(x, y);
                check_rgb($sformatf("rgb row %0d x=%0d y=%0d", r, x, y), red, green, blue,
                          {2{c[11:8]}}, {2{c[7:4]}}, {2{c[3:0]}});
                x = x + 1;
            end else begin
                check_rgb($sformatf("rgb in blanking row %0d", r), red, green, blue,
                          8'd0, 8'd0, 8'd0);
                if (was_active) begin
                    check_count("active pixels per line", x, H_ACTIVE);
                    x = 0;
                    y = y + 1;
                end
            end
            was_active = lhbl_dly && lvbl_dly;
        end
        check_count("active lines per frame", y, V_ACTIVE);
    endtask

    initial begin
        rst_n     = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_we    = 1'b0;
        layer0_cs = 1'b0;
        layer1_cs = 1'b0;
        pal_cs    = 1'b0;
        ctrl_cs   = 1'b0;
        void'($urandom(62));
        load_table();
        fill_roms();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        fill_maps();
        rewrite_palette();
        cpu_idle();
        wait_vblank_start();
        for (int r = 0; r < N_ROWS; r++) begin
            apply_row(r);
            check_frame(r);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/video_top.sv
/*
 * Tile video subsystem top level
 * Connects the timing generator, two scrolling tile layers
 * and the colour mixer
 */

`timescale 1ns/1ps
`default_nettype none

module video_top import video_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,

    // CPU writes
    input  wire logic [CPU_AW-1:0] cpu_addr,
    input  wire logic [CPU_DW-1:0] cpu_dout,
    input  wire logic              cpu_we,
    input  wire logic              layer0_cs,
    input  wire logic              layer1_cs,
    input  wire logic              pal_cs,
    input  wire logic              ctrl_cs,

    // Graphics ROMs
    input  wire logic [ROM_DW-1:0] rom0_data,
    input  wire logic [ROM_DW-1:0] rom1_data,
    output logic      [ROM_AW-1:0] rom0_addr,
    output logic      [ROM_AW-1:0] rom1_addr,

    // Video out
    output logic                   hs,
    output logic                   vs,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly,
    output logic      [7:0]        red,
    output logic      [7:0]        green,
    output logic      [7:0]        blue
);

    logic             pxl_cen;
    logic [8:0]       hdump;
    logic [8:0]       vdump;
    logic             lhbl;
    logic             lvbl;
    logic [PXL_W-1:0] layer0_pxl;
    logic [PXL_W-1:0] layer1_pxl;

    video_timing u_timing (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .hdump    ( hdump     ),
        .vdump    ( vdump     ),
        .lhbl     ( lhbl      ),
        .lvbl     ( lvbl      ),
        .hs       ( hs        ),
        .vs       ( vs        )
    );

    tile_layer u_layer0 (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .hdump    ( hdump     ),
        .vdump    ( vdump     ),
        .layer_cs ( layer0_cs ),
        .cpu_we   ( cpu_we    ),
        .cpu_addr ( cpu_addr  ),
        .cpu_dout ( cpu_dout  ),
        .rom_data ( rom0_data ),
        .rom_addr ( rom0_addr ),
        .pxl      ( layer0_pxl )
    );

    tile_layer u_layer1 (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .hdump    ( hdump     ),
        .vdump    ( vdump     ),
        .layer_cs ( layer1_cs ),
        .cpu_we   ( cpu_we    ),
        .cpu_addr ( cpu_addr  ),
        .cpu_dout ( cpu_dout  ),
        .rom_data ( rom1_data ),
        .rom_addr ( rom1_addr ),
        .pxl      ( layer1_pxl )
    );

    color_mixer u_mixer (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .pxl_cen    ( pxl_cen    ),
        .lhbl       ( lhbl       ),
        .lvbl       ( lvbl       ),
        .pal_cs     ( pal_cs     ),
        .ctrl_cs    ( ctrl_cs    ),
        .cpu_we     ( cpu_we     ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .layer0_pxl ( layer0_pxl ),
        .layer1_pxl ( layer1_pxl ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .lhbl_dly   ( lhbl_dly   ),
        .lvbl_dly   ( lvbl_dly   )
    );

endmodule

`default_nettype wire

//--- hw/color_mixer.sv
/*
 * Colour mixer
 * Holds the palette and the control word, picks the front
 * layer pixel from priority, enables and transparency, looks
 * up its colour and drives RGB with the blanking delayed to match
 */

`timescale 1ns/1ps
`default_nettype none

module color_mixer import video_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              pxl_cen,
    input  wire logic              lhbl,
    input  wire logic              lvbl,
    input  wire logic              pal_cs,
    input  wire logic              ctrl_cs,
    input  wire logic              cpu_we,
    input  wire logic [CPU_AW-1:0] cpu_addr,
    input  wire logic [CPU_DW-1:0] cpu_dout,
    input  wire logic [PXL_W-1:0]  layer0_pxl,
    input  wire logic [PXL_W-1:0]  layer1_pxl,
    output logic      [7:0]        red,
    output logic      [7:0]        green,
    output logic      [7:0]        blue,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly
);

    logic [PAL_DW-1:0] pal_mem [2**PAL_AW];

    logic ctrl_prio;
    logic ctrl_en0;
    logic ctrl_en1;

    logic              l0_on;
    logic              l1_on;
    logic [PAL_AW-1:0] pal_rd_addr;
    logic [PAL_DW-1:0] pal_rd;

    // Blanking pipe covering the layer and mixer stages
    logic [LAYER_LAT+MIX_LAT-1:0] hbl_sr;
    logic [LAYER_LAT+MIX_LAT-1:0] vbl_sr;
    logic                         active;

    always_ff @(posedge clk) begin
        if (pal_cs && cpu_we) begin
            pal_mem[cpu_addr[PAL_AW-1:0]] <= cpu_dout[PAL_DW-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_prio <= 1'b0;
            ctrl_en0  <= 1'b1;
            ctrl_en1  <= 1'b1;
        end else if (ctrl_cs && cpu_we) begin
            ctrl_prio <= cpu_dout[CTRL_PRIO_BIT];
            ctrl_en0  <= cpu_dout[CTRL_EN0_BIT];
            ctrl_en1  <= cpu_dout[CTRL_EN1_BIT];
        end
    end

    // Colour index 0 is see-through
    assign l0_on = ctrl_en0 && (layer0_pxl[PXL_W/2-1:0] != '0);
    assign l1_on = ctrl_en1 && (layer1_pxl[PXL_W/2-1:0] != '0);

    // Layer 1 in front unless the priority bit is set
    always_comb begin
        if (l0_on && (ctrl_prio || !l1_on)) begin
            pal_rd_addr = {1'b0, layer0_pxl};
        end else if (l1_on) begin
            pal_rd_addr = {1'b1, layer1_pxl};
        end else begin
            pal_rd_addr = '0;
        end
    end

    assign pal_rd = pal_mem[pal_rd_addr];

    // Blanking for the pixel now leaving the layers
    assign active = hbl_sr[LAYER_LAT-1] && vbl_sr[LAYER_LAT-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
            red    <= 8'd0;
            green  <= 8'd0;
            blue   <= 8'd0;
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[LAYER_LAT+MIX_LAT-2:0], lhbl};
            vbl_sr <= {vbl_sr[LAYER_LAT+MIX_LAT-2:0], lvbl};
            if (active) begin
                red   <= {pal_rd[11:8], pal_rd[11:8]};
                green <= {pal_rd[7:4], pal_rd[7:4]};
                blue  <= {pal_rd[3:0], pal_rd[3:0]};
            end else begin
                red   <= 8'd0;
                green <= 8'd0;
                blue  <= 8'd0;
            end
        end
    end

    assign lhbl_dly = hbl_sr[LAYER_LAT+MIX_LAT-1];
    assign lvbl_dly = vbl_sr[LAYER_LAT+MIX_LAT-1];

    a_hblank_within_vblank: assert property (
        @(posedge clk) disable iff (!rst_n)
        lhbl_dly |-> lvbl_dly
    );

endmodule

`default_nettype wire

//--- hw/tile_layer.sv
/*
 * Scrolling tile layer
 * Holds the tile map and the scroll registers, fetches tile
 * rows from an external graphics ROM and outputs one pixel
 * per pixel clock, three pixel clocks after the beam position
 */

`timescale 1ns/1ps
`default_nettype none

module tile_layer import video_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              pxl_cen,
    input  wire logic [8:0]        hdump,
    input  wire logic [8:0]        vdump,
    input  wire logic              layer_cs,
    input  wire logic              cpu_we,
    input  wire logic [CPU_AW-1:0] cpu_addr,
    input  wire logic [CPU_DW-1:0] cpu_dout,
    input  wire logic [ROM_DW-1:0] rom_data,
    output logic      [ROM_AW-1:0] rom_addr,
    output logic      [PXL_W-1:0]  pxl
);

    logic [CPU_DW-1:0] map_mem [2**MAP_AW];

    logic [MAP_XW-1:0] scroll_h;
    logic [MAP_YW-1:0] scroll_v;
    logic [MAP_XW-1:0] pos_x;
    logic [MAP_YW-1:0] pos_y;
    logic [MAP_AW-1:0] map_rd_addr;

    // Stage 1 holds the map entry and the position inside the tile
    logic [CPU_DW-1:0] map_q;
    logic [TILE_W-1:0] row_1;
    logic [TILE_W-1:0] col_1;

    // Stage 2 runs alongside the ROM fetch
    logic [3:0]        pal_2;
    logic [TILE_W-1:0] col_2;

    logic [3:0]        nibble;

    // Map starts cleared as loaded into block RAM
    initial begin
        for (int i = 0; i < 2**MAP_AW; i++) begin
            map_mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (layer_cs && cpu_we && (cpu_addr < SCROLL_H_ADDR)) begin
            map_mem[cpu_addr[MAP_AW-1:0]] <= cpu_dout;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scroll_h <= '0;
            scroll_v <= '0;
        end else if (layer_cs && cpu_we) begin
            if (cpu_addr == SCROLL_H_ADDR) begin
                scroll_h <= cpu_dout[MAP_XW-1:0];
            end
            if (cpu_addr == SCROLL_V_ADDR) begin
                scroll_v <= cpu_dout[MAP_YW-1:0];
            end
        end
    end

    // Wraps at the map size through the counter widths
    assign pos_x       = hdump[MAP_XW-1:0] + scroll_h;
    assign pos_y       = vdump[MAP_YW-1:0] + scroll_v;
    assign map_rd_addr = {pos_y[MAP_YW-1:TILE_W], pos_x[MAP_XW-1:TILE_W]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_q <= '0;
            row_1 <= '0;
            col_1 <= '0;
            pal_2 <= '0;
            col_2 <= '0;
        end else if (pxl_cen) begin
            map_q <= map_mem[map_rd_addr];
            row_1 <= pos_y[TILE_W-1:0];
            col_1 <= pos_x[TILE_W-1:0];
            pal_2 <= map_q[11:8];
            col_2 <= col_1;
        end
    end

    // Leftmost pixel sits in the top nibble
    assign nibble = rom_data[(ROM_DW/4 - 1 - col_2) * 4 +: 4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rom_addr <= '0;
            pxl      <= '0;
        end else if (pxl_cen) begin
            rom_addr <= {map_q[7:0], row_1};
            // ROM word arrived one clock after the address
            pxl      <= {pal_2, nibble};
        end
    end

    a_rom_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(rom_addr)
    );

endmodule

`default_nettype wire

//--- hw/video_timing.sv
/*
 * Video timing generator
 * Divides the clock by two for the pixel enable, runs the
 * horizontal and vertical beam counters and decodes the
 * blanking and sync levels as registered outputs
 */

`timescale 1ns/1ps
`default_nettype none

module video_timing import video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    output logic            pxl_cen,
    output logic [8:0]      hdump,
    output logic [8:0]      vdump,
    output logic            lhbl,
    output logic            lvbl,
    output logic            hs,
    output logic            vs
);

    logic [8:0] h_next;
    logic [8:0] v_next;

    // Counter values after the coming pixel step
    always_comb begin
        h_next = (hdump == H_TOTAL - 1) ? 9'd0 : hdump + 9'd1;
        v_next = vdump;
        if (hdump == H_TOTAL - 1) begin
            v_next = (vdump == V_TOTAL - 1) ? 9'd0 : vdump + 9'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // Levels are decoded from the next counts so they stay aligned with hdump
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= 9'd0;
            vdump <= 9'd0;
            lhbl  <= 1'b1;
            lvbl  <= 1'b1;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_next;
            vdump <= v_next;
            // Horizontal blank also covers the lines of vertical blank
            lhbl  <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
            lvbl  <= v_next < V_ACTIVE;
            hs    <= (h_next >= HS_START) && (h_next < HS_START + HS_LEN);
            vs    <= (v_next >= VS_START) && (v_next < VS_START + VS_LEN);
        end
    end

    a_counters_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (hdump < H_TOTAL) && (vdump < V_TOTAL)
    );

endmodule

`default_nettype wire

//--- hw/video_pkg.sv
/*
 * Video subsystem constants
 * Screen geometry, tile map layout, graphics ROM format,
 * palette format, pipeline depths and CPU bus widths
 */

`default_nettype none

package video_pkg;

    // Screen geometry in pixel clocks and lines
    localparam int H_TOTAL  = 64;
    localparam int H_ACTIVE = 48;
    localparam int V_TOTAL  = 40;
    localparam int V_ACTIVE = 32;
    localparam int HS_START = 52;
    localparam int HS_LEN   = 4;
    localparam int VS_START = 34;
    localparam int VS_LEN   = 2;

    // Tile map, 16 by 8 tiles of 8 by 8 pixels
    localparam int TILE_SIZE     = 8;
    localparam int MAP_COLS      = 16;
    localparam int MAP_ROWS      = 8;
    localparam int MAP_AW        = 7;
    localparam int SCROLL_H_ADDR = 128;
    localparam int SCROLL_V_ADDR = 129;
    localparam int TILE_W        = $clog2(TILE_SIZE);
    localparam int MAP_XW        = $clog2(MAP_COLS * TILE_SIZE);
    localparam int MAP_YW        = $clog2(MAP_ROWS * TILE_SIZE);

    // Graphics ROM, one word per tile row
    localparam int ROM_AW = 11;
    localparam int ROM_DW = 32;

    // Layer pixels and palette
    localparam int PXL_W  = 8;
    localparam int PAL_AW = 9;
    localparam int PAL_DW = 12;

    // Pipeline depths in pixel clocks
    localparam int LAYER_LAT = 3;
    localparam int MIX_LAT   = 1;

    // CPU bus and control word bits
    localparam int CPU_AW        = 11;
    localparam int CPU_DW        = 16;
    localparam int CTRL_PRIO_BIT = 0;
    localparam int CTRL_EN0_BIT  = 1;
    localparam int CTRL_EN1_BIT  = 2;

endpackage

`default_nettype wire
